//--- arcade_cfg.svh
// Arcade adapter widths
// Joystick, audio and colour sizes

`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// ================================================
// Joystick word
// ================================================
`define ARC_JOY_W      8
`define ARC_JOY_RIGHT  0
`define ARC_JOY_LEFT   1
`define ARC_JOY_DOWN   2
`define ARC_JOY_UP     3
`define ARC_JOY_FIRE   4
`define ARC_JOY_BOMB   5

// ================================================
// Audio
// ================================================
`define ARC_SND_W      8   // Per core channel
`define ARC_MIX_W      11  // 4*B + A
`define ARC_DAC_W      16  // Mix padded with zeros below

// Colour channels, core side and VGA side
`define ARC_COL_IN_W   3
`define ARC_COL_OUT_W  6

`endif

//--- arcade_pkg.sv
// Arcade adapter types

package arcade_pkg;

	// Keyboard event word layout
	localparam int unsigned KEY_EV_W       = 11;
	localparam int unsigned KEY_TOGGLE_BIT = 10;
	localparam int unsigned KEY_PRESS_BIT  = 9;

	localparam int unsigned BTN_N = 10;  // Keyboard buttons tracked

	// Scan codes that the cabinet reacts to
	typedef enum logic [7:0] {
		KEY_START1 = 8'h05,  // F1
		KEY_START2 = 8'h06,  // F2
		KEY_FIRE2  = 8'h11,  // Alt
		KEY_FIRE3  = 8'h14,  // Ctrl
		KEY_FIRE1  = 8'h29,  // Space
		KEY_LEFT   = 8'h6B,
		KEY_DOWN   = 8'h72,
		KEY_RIGHT  = 8'h74,
		KEY_UP     = 8'h75,
		KEY_COIN   = 8'h76   // Esc
	} key_code_e;

	// Bit positions in the button vector
	typedef enum logic [3:0] {
		BTN_UP     = 4'd0,
		BTN_DOWN   = 4'd1,
		BTN_LEFT   = 4'd2,
		BTN_RIGHT  = 4'd3,
		BTN_COIN   = 4'd4,
		BTN_START1 = 4'd5,
		BTN_START2 = 4'd6,
		BTN_FIRE1  = 4'd7,
		BTN_FIRE2  = 4'd8,
		BTN_FIRE3  = 4'd9
	} btn_idx_e;

endpackage

//--- key_decoder.sv
// Keyboard event decoder
// Toggle-marked scan codes to held button levels

module key_decoder (
	input  logic                                clk_24,
	input  logic                                arst_n,
	input  logic [arcade_pkg::KEY_EV_W-1:0]     key_event,
	output logic [arcade_pkg::BTN_N-1:0]        buttons
);

	logic                  toggle_q;  // Toggle bit from the previous cycle
	logic                  new_event;
	logic                  pressed;
	arcade_pkg::key_code_e code;

	// A fresh event is marked only by a flip of the toggle bit
	assign new_event = key_event[arcade_pkg::KEY_TOGGLE_BIT] != toggle_q;
	assign pressed   = key_event[arcade_pkg::KEY_PRESS_BIT];
	assign code      = arcade_pkg::key_code_e'(key_event[7:0]);

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= key_event[arcade_pkg::KEY_TOGGLE_BIT];
		end
	end

	// ================================================
	// Button levels
	// ================================================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;
		end else if (new_event) begin
			case (code)
				arcade_pkg::KEY_UP:
					buttons[arcade_pkg::BTN_UP] <= pressed;
				arcade_pkg::KEY_DOWN:
					buttons[arcade_pkg::BTN_DOWN] <= pressed;
				arcade_pkg::KEY_LEFT:
					buttons[arcade_pkg::BTN_LEFT] <= pressed;
				arcade_pkg::KEY_RIGHT:
					buttons[arcade_pkg::BTN_RIGHT] <= pressed;
				arcade_pkg::KEY_COIN:
					buttons[arcade_pkg::BTN_COIN] <= pressed;
				arcade_pkg::KEY_START1:
					buttons[arcade_pkg::BTN_START1] <= pressed;
				arcade_pkg::KEY_START2:
					buttons[arcade_pkg::BTN_START2] <= pressed;
				arcade_pkg::KEY_FIRE1:
					buttons[arcade_pkg::BTN_FIRE1] <= pressed;
				arcade_pkg::KEY_FIRE2:
					buttons[arcade_pkg::BTN_FIRE2] <= pressed;
				arcade_pkg::KEY_FIRE3:
					buttons[arcade_pkg::BTN_FIRE3] <= pressed;
				default: begin
					// Other keys leave every level alone
				end
			endcase
		end
	end

endmodule

//--- control_mapper.sv
// Player control mapper
// Keyboard and joystick merge with cabinet rotation

`include "arcade_cfg.svh"

module control_mapper (
	input  logic                          clk_24,
	input  logic                          arst_n,
	input  logic [arcade_pkg::BTN_N-1:0]  buttons,
	input  logic [`ARC_JOY_W-1:0]         joy_0,
	input  logic [`ARC_JOY_W-1:0]         joy_1,
	input  logic                          rotate,
	output logic                          ctl_up,
	output logic                          ctl_down,
	output logic                          ctl_left,
	output logic                          ctl_right,
	output logic                          ctl_fire,
	output logic                          ctl_bomb,
	output logic                          ctl_coin,
	output logic                          ctl_start1,
	output logic                          ctl_start2
);

	logic src_up, src_down, src_left, src_right;
	logic src_fire, src_bomb;

	// Each source is keyboard OR either stick
	assign src_up    = buttons[arcade_pkg::BTN_UP] | joy_0[`ARC_JOY_UP] | joy_1[`ARC_JOY_UP];
	assign src_down  = buttons[arcade_pkg::BTN_DOWN] | joy_0[`ARC_JOY_DOWN]
		| joy_1[`ARC_JOY_DOWN];
	assign src_left  = buttons[arcade_pkg::BTN_LEFT] | joy_0[`ARC_JOY_LEFT]
		| joy_1[`ARC_JOY_LEFT];
	assign src_right = buttons[arcade_pkg::BTN_RIGHT] | joy_0[`ARC_JOY_RIGHT]
		| joy_1[`ARC_JOY_RIGHT];
	assign src_fire  = buttons[arcade_pkg::BTN_FIRE1] | joy_0[`ARC_JOY_FIRE]
		| joy_1[`ARC_JOY_FIRE];
	assign src_bomb  = buttons[arcade_pkg::BTN_FIRE2] | joy_0[`ARC_JOY_BOMB]
		| joy_1[`ARC_JOY_BOMB];

	// ================================================
	// Output register
	// ================================================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			{ctl_up, ctl_down, ctl_left, ctl_right} <= 4'b0000;
			{ctl_fire, ctl_bomb}                    <= 2'b00;
			{ctl_coin, ctl_start1, ctl_start2}      <= 3'b000;
		end else begin
			// Rotate low means the monitor sits a quarter turn round
			ctl_up     <= rotate ? src_up    : src_left;
			ctl_down   <= rotate ? src_down  : src_right;
			ctl_left   <= rotate ? src_left  : src_down;
			ctl_right  <= rotate ? src_right : src_up;
			ctl_fire   <= src_fire;
			ctl_bomb   <= src_bomb;
			ctl_coin   <= buttons[arcade_pkg::BTN_COIN];    // Keyboard only
			ctl_start1 <= buttons[arcade_pkg::BTN_START1];
			ctl_start2 <= buttons[arcade_pkg::BTN_START2];
		end
	end

endmodule

//--- audio_dac.sv
// Sound mixer and sigma-delta DAC

`include "arcade_cfg.svh"

module audio_dac (
	input  logic                  clk_24,
	input  logic                  arst_n,
	input  logic                  sample_strobe,
	input  logic [`ARC_SND_W-1:0] snd_a,
	input  logic [`ARC_SND_W-1:0] snd_b,
	output logic                  audio_l,
	output logic                  audio_r
);

	logic [`ARC_MIX_W-1:0] mix_d;
	logic [`ARC_MIX_W-1:0] mix_q;      // Latched sample
	logic [`ARC_DAC_W-1:0] dac_word;
	logic [`ARC_DAC_W-1:0] acc_q;
	logic [`ARC_DAC_W:0]   acc_sum;    // One extra bit for the carry
	logic                  dac_bit_q;

	// ================================================
	// Mixer
	// ================================================
	// Channel B weighs four times channel A
	assign mix_d = `ARC_MIX_W'({snd_b, 2'b00}) + `ARC_MIX_W'(snd_a);

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			mix_q <= '0;
		end else if (sample_strobe) begin
			mix_q <= mix_d;
		end
	end

	// Left-justify the mix in the DAC word
	assign dac_word = {mix_q, {(`ARC_DAC_W - `ARC_MIX_W){1'b0}}};

	// ================================================
	// First-order sigma-delta
	// ================================================
	assign acc_sum = {1'b0, acc_q} + {1'b0, dac_word};

	// Carry density over 2^16 cycles equals dac_word
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			acc_q     <= '0;
			dac_bit_q <= 1'b0;
		end else begin
			acc_q     <= acc_sum[`ARC_DAC_W-1:0];
			dac_bit_q <= acc_sum[`ARC_DAC_W];
		end
	end

	// Mono board, same stream on both pins
	assign audio_l = dac_bit_q;
	assign audio_r = dac_bit_q;

endmodule

//--- video_shade.sv
// Pixel shading pipeline
// Blanking, colour widening and scanline dimming

`include "arcade_cfg.svh"

module video_shade (
	input  logic                      clk_24,
	input  logic                      arst_n,
	input  logic                      ce_pix,
	input  logic [`ARC_COL_IN_W-1:0]  red_in,
	input  logic [`ARC_COL_IN_W-1:0]  green_in,
	input  logic [`ARC_COL_IN_W-1:0]  blue_in,
	input  logic                      hblank,
	input  logic                      vblank,
	input  logic                      hsync_in,
	input  logic                      vsync_in,
	input  logic [1:0]                scanlines,
	output logic [`ARC_COL_OUT_W-1:0] red,
	output logic [`ARC_COL_OUT_W-1:0] green,
	output logic [`ARC_COL_OUT_W-1:0] blue,
	output logic                      hsync,
	output logic                      vsync
);

	logic [`ARC_COL_OUT_W-1:0] red_1, green_1, blue_1;
	logic                      hs_1, vs_1;
	logic                      odd_line;   // Parity of the line in stage one
	logic                      blank;
	logic                      dim_en;

	// Repeat the 3 bits so full scale maps to full scale
	function automatic logic [`ARC_COL_OUT_W-1:0] widen(input logic [`ARC_COL_IN_W-1:0] c);
		return {2{c}};
	endfunction

	// c - lvl * (c / 4)
	function automatic logic [`ARC_COL_OUT_W-1:0] darken(
		input logic [`ARC_COL_OUT_W-1:0] c,
		input logic [1:0]                lvl
	);
		logic [`ARC_COL_OUT_W-1:0] step;
		step = c[`ARC_COL_OUT_W-1:2] * lvl;
		return c - step;
	endfunction

	assign blank  = hblank | vblank;
	assign dim_en = odd_line && (scanlines != 2'd0);

	// ================================================
	// Stage one
	// ================================================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			{red_1, green_1, blue_1} <= '0;
			{hs_1, vs_1, odd_line}   <= 3'b000;
		end else if (ce_pix) begin
			red_1   <= blank ? '0 : widen(red_in);
			green_1 <= blank ? '0 : widen(green_in);
			blue_1  <= blank ? '0 : widen(blue_in);
			hs_1    <= hsync_in;
			vs_1    <= vsync_in;
			if (vsync_in && !vs_1) begin
				odd_line <= 1'b0;            // New frame starts even
			end else if (hsync_in && !hs_1) begin
				odd_line <= ~odd_line;
			end
		end
	end

	// ================================================
	// Stage two
	// ================================================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			{red, green, blue} <= '0;
			{hsync, vsync}     <= 2'b00;
		end else if (ce_pix) begin
			red   <= dim_en ? darken(red_1, scanlines) : red_1;
			green <= dim_en ? darken(green_1, scanlines) : green_1;
			blue  <= dim_en ? darken(blue_1, scanlines) : blue_1;
			hsync <= hs_1;
			vsync <= vs_1;
		end
	end

endmodule

//--- arcade_io_top.sv
// Arcade board-side adapter
// Controls, audio and video around the core

`include "arcade_cfg.svh"

module arcade_io_top (
	input  logic                            clk_24,
	input  logic                            arst_n,
	// Keyboard and sticks
	input  logic [arcade_pkg::KEY_EV_W-1:0] key_event,
	input  logic [`ARC_JOY_W-1:0]           joy_0,
	input  logic [`ARC_JOY_W-1:0]           joy_1,
	input  logic                            rotate,
	output logic                            ctl_up,
	output logic                            ctl_down,
	output logic                            ctl_left,
	output logic                            ctl_right,
	output logic                            ctl_fire,
	output logic                            ctl_bomb,
	output logic                            ctl_coin,
	output logic                            ctl_start1,
	output logic                            ctl_start2,
	// Sound
	input  logic                            sample_strobe,
	input  logic [`ARC_SND_W-1:0]           snd_a,
	input  logic [`ARC_SND_W-1:0]           snd_b,
	output logic                            audio_l,
	output logic                            audio_r,
	// Video
	input  logic                            ce_pix,
	input  logic [`ARC_COL_IN_W-1:0]        red_in,
	input  logic [`ARC_COL_IN_W-1:0]        green_in,
	input  logic [`ARC_COL_IN_W-1:0]        blue_in,
	input  logic                            hblank,
	input  logic                            vblank,
	input  logic                            hsync_in,
	input  logic                            vsync_in,
	input  logic [1:0]                      scanlines,
	output logic [`ARC_COL_OUT_W-1:0]       red,
	output logic [`ARC_COL_OUT_W-1:0]       green,
	output logic [`ARC_COL_OUT_W-1:0]       blue,
	output logic                            hsync,
	output logic                            vsync
);

	logic [arcade_pkg::BTN_N-1:0] buttons;  // Decoder to mapper

	// ================================================
	// Control path
	// ================================================
	key_decoder i_key_decoder (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.key_event (key_event),
		.buttons   (buttons)
	);

	control_mapper i_control_mapper (
		.clk_24     (clk_24),
		.arst_n     (arst_n),
		.buttons    (buttons),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.rotate     (rotate),
		.ctl_up     (ctl_up),
		.ctl_down   (ctl_down),
		.ctl_left   (ctl_left),
		.ctl_right  (ctl_right),
		.ctl_fire   (ctl_fire),
		.ctl_bomb   (ctl_bomb),
		.ctl_coin   (ctl_coin),
		.ctl_start1 (ctl_start1),
		.ctl_start2 (ctl_start2)
	);

	// Audio and video paths
	audio_dac i_audio_dac (
		.clk_24        (clk_24),
		.arst_n        (arst_n),
		.sample_strobe (sample_strobe),
		.snd_a         (snd_a),
		.snd_b         (snd_b),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

	video_shade i_video_shade (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.ce_pix    (ce_pix),
		.red_in    (red_in),
		.green_in  (green_in),
		.blue_in   (blue_in),
		.hblank    (hblank),
		.vblank    (vblank),
		.hsync_in  (hsync_in),
		.vsync_in  (vsync_in),
		.scanlines (scanlines),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hsync     (hsync),
		.vsync     (vsync)
	);

endmodule

//--- arcade_io_assert.sv
// Adapter output assertions

`include "arcade_cfg.svh"

module arcade_io_assert (
	input logic                            clk_24,
	input logic                            arst_n,
	input logic [arcade_pkg::BTN_N-1:0]    buttons,
	input logic [`ARC_JOY_W-1:0]           joy_0,
	input logic [`ARC_JOY_W-1:0]           joy_1,
	input logic                            rotate,
	input logic                            ctl_up, ctl_down, ctl_left, ctl_right,
	input logic                            ctl_fire, ctl_bomb,
	input logic                            ctl_coin, ctl_start1, ctl_start2,
	input logic                            audio_l, audio_r,
	input logic                            ce_pix, hblank, vblank, hsync_in, vsync_in,
	input logic [`ARC_COL_OUT_W-1:0]       red, green, blue,
	input logic                            hsync, vsync
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;  // Read by the testbench at the end

	logic       src_up, src_down, src_left, src_right;
	logic [3:0] dir_exp;          // Order up, down, left, right
	logic [1:0] hs_d, vs_d, blank_d;

	assign src_up    = buttons[arcade_pkg::BTN_UP] | joy_0[`ARC_JOY_UP] | joy_1[`ARC_JOY_UP];
	assign src_down  = buttons[arcade_pkg::BTN_DOWN] | joy_0[`ARC_JOY_DOWN]
		| joy_1[`ARC_JOY_DOWN];
	assign src_left  = buttons[arcade_pkg::BTN_LEFT] | joy_0[`ARC_JOY_LEFT]
		| joy_1[`ARC_JOY_LEFT];
	assign src_right = buttons[arcade_pkg::BTN_RIGHT] | joy_0[`ARC_JOY_RIGHT]
		| joy_1[`ARC_JOY_RIGHT];
	// Quarter turn when rotate is low
	assign dir_exp = rotate ? {src_up, src_down, src_left, src_right}
		: {src_left, src_right, src_down, src_up};

	// Reference delay of two pixel strobes
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			hs_d    <= 2'b00;
			vs_d    <= 2'b00;
			blank_d <= 2'b00;
		end else if (ce_pix) begin
			hs_d    <= {hs_d[0], hsync_in};
			vs_d    <= {vs_d[0], vsync_in};
			blank_d <= {blank_d[0], hblank | vblank};
		end
	end

	// ================================================
	// Checks
	// ================================================
	dir_map: assert property (@(posedge clk_24) disable iff (!arst_n)
		{ctl_up, ctl_down, ctl_left, ctl_right} == $past(dir_exp))
	else begin
		$error("Direction controls do not follow the merged and rotated sources");
		fail_count++;
	end

	fire_bomb: assert property (@(posedge clk_24) disable iff (!arst_n)
		{ctl_fire, ctl_bomb} == $past({buttons[arcade_pkg::BTN_FIRE1] | joy_0[`ARC_JOY_FIRE]
		| joy_1[`ARC_JOY_FIRE], buttons[arcade_pkg::BTN_FIRE2] | joy_0[`ARC_JOY_BOMB]
		| joy_1[`ARC_JOY_BOMB]}))
	else begin
		$error("Fire or bomb does not follow its sources");
		fail_count++;
	end

	kbd_only: assert property (@(posedge clk_24) disable iff (!arst_n)
		{ctl_coin, ctl_start1, ctl_start2} == $past({buttons[arcade_pkg::BTN_COIN],
		buttons[arcade_pkg::BTN_START1], buttons[arcade_pkg::BTN_START2]}))
	else begin
		$error("Coin or start does not follow the keyboard");
		fail_count++;
	end

	audio_pair: assert property (@(posedge clk_24) audio_r == audio_l)
	else begin
		$error("Right audio pin differs from left");
		fail_count++;
	end

	sync_delay: assert property (@(posedge clk_24) disable iff (!arst_n)
		{hsync, vsync} == {hs_d[1], vs_d[1]})
	else begin
		$error("Syncs are not delayed by two pixel strobes");
		fail_count++;
	end

	blank_black: assert property (@(posedge clk_24) disable iff (!arst_n)
		blank_d[1] |-> {red, green, blue} == 18'd0)
	else begin
		$error("Blanked pixel is not black");
		fail_count++;
	end

endmodule

bind arcade_io_top arcade_io_assert i_assert (
	.clk_24(clk_24), .arst_n(arst_n), .buttons(buttons), .joy_0(joy_0), .joy_1(joy_1),
	.rotate(rotate), .ctl_up(ctl_up), .ctl_down(ctl_down), .ctl_left(ctl_left),
	.ctl_right(ctl_right), .ctl_fire(ctl_fire), .ctl_bomb(ctl_bomb), .ctl_coin(ctl_coin),
	.ctl_start1(ctl_start1), .ctl_start2(ctl_start2), .audio_l(audio_l), .audio_r(audio_r),
	.ce_pix(ce_pix), .hblank(hblank), .vblank(vblank), .hsync_in(hsync_in),
	.vsync_in(vsync_in), .red(red), .green(green), .blue(blue), .hsync(hsync), .vsync(vsync)
);

//--- tb_arcade_io.sv
// Adapter testbench
// Keyboard, sticks, sound and pixels

`include "arcade_cfg.svh"

module tb_arcade_io;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 200000;  // Two 64k audio windows plus the rest

	logic                      clk_24, arst_n;
	logic [10:0]               key_event;
	logic [`ARC_JOY_W-1:0]     joy_0, joy_1;
	logic                      rotate;
	logic                      ctl_up, ctl_down, ctl_left, ctl_right;
	logic                      ctl_fire, ctl_bomb, ctl_coin, ctl_start1, ctl_start2;
	logic                      sample_strobe, audio_l, audio_r;
	logic [`ARC_SND_W-1:0]     snd_a, snd_b;
	logic                      ce_pix, hblank, vblank, hsync_in, vsync_in;
	logic [`ARC_COL_IN_W-1:0]  red_in, green_in, blue_in;
	logic [1:0]                scanlines;
	logic [`ARC_COL_OUT_W-1:0] red, green, blue;
	logic                      hsync, vsync;

	logic [8:0]  ctl_vec;
	logic        tgl = 1'b0;      // Keyboard toggle bit
	logic        odd = 1'b0;      // Line parity model
	logic        hs_prev = 1'b0;
	logic        vs_prev = 1'b0;
	logic [17:0] exp_q[$];        // Expected pixels in flight
	int          errors = 0;
	int          cycles = 0;
	logic [7:0]  dir_codes[4] = '{arcade_pkg::KEY_RIGHT, arcade_pkg::KEY_LEFT,
		arcade_pkg::KEY_DOWN, arcade_pkg::KEY_UP};  // By joystick bit

	assign ctl_vec = {ctl_up, ctl_down, ctl_left, ctl_right, ctl_fire, ctl_bomb,
		ctl_coin, ctl_start1, ctl_start2};

	arcade_io_top i_dut (.*);

	initial begin
		clk_24 = 1'b0;
		forever #4 clk_24 = ~clk_24;
	end

	always @(posedge clk_24) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			finish_run(1'b1);
		end
	end

	// ================================================
	// Helpers
	// ================================================
	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic finish_run(input logic timeout);
		int unsigned asrt_errors;
		asrt_errors = i_dut.i_assert.fail_count;
		$display("Errors: %0d value, %0d assertion", errors, asrt_errors);
		if (!timeout && errors == 0 && asrt_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	// Control expected for a key with rotate high
	function automatic logic [8:0] key_ctl(input logic [7:0] code);
		case (code)
			arcade_pkg::KEY_UP:     return 9'b100000000;
			arcade_pkg::KEY_DOWN:   return 9'b010000000;
			arcade_pkg::KEY_LEFT:   return 9'b001000000;
			arcade_pkg::KEY_RIGHT:  return 9'b000100000;
			arcade_pkg::KEY_FIRE1:  return 9'b000010000;
			arcade_pkg::KEY_FIRE2:  return 9'b000001000;
			arcade_pkg::KEY_COIN:   return 9'b000000100;
			arcade_pkg::KEY_START1: return 9'b000000010;
			arcade_pkg::KEY_START2: return 9'b000000001;
			default:                return 9'b000000000;  // Fire3 drives nothing
		endcase
	endfunction

	// Odd lines lose level quarters of the colour
	function automatic logic [5:0] shade(input logic [5:0] w, input logic odd_line,
		input logic [1:0] lvl);
		int v;
		v = int'(w);
		if (odd_line && lvl != 2'd0) begin
			v = v - int'(lvl) * (v / 4);
		end
		return 6'(v);
	endfunction

	task automatic send_key(input logic [7:0] code, input logic press, input logic new_event);
		@(negedge clk_24);
		if (new_event) begin
			tgl = ~tgl;
		end
		key_event = {tgl, press, 1'b0, code};
		repeat (2) @(negedge clk_24);  // Decoder plus mapper
	endtask

	task automatic send_pixel(input logic [2:0] r, g, b, input logic hb, vb, hs, vs);
		logic [17:0] exp;
		@(negedge clk_24);
		{red_in, green_in, blue_in} = {r, g, b};
		{hblank, vblank, hsync_in, vsync_in} = {hb, vb, hs, vs};
		ce_pix = 1'b1;
		if (vs && !vs_prev) begin
			odd = 1'b0;
		end else if (hs && !hs_prev) begin
			odd = ~odd;
		end
		{hs_prev, vs_prev} = {hs, vs};
		exp = (hb || vb) ? 18'd0 : {shade({r, r}, odd, scanlines),
			shade({g, g}, odd, scanlines), shade({b, b}, odd, scanlines)};
		exp_q.push_back(exp);
		@(negedge clk_24);
		ce_pix = 1'b0;
		if (exp_q.size() > 1) begin
			check_value("pixel", int'({red, green, blue}), int'(exp_q.pop_front()));
		end
		repeat ($urandom % 3) @(negedge clk_24);
	endtask

	// ================================================
	// Test sequences
	// ================================================
	task automatic run_keyboard();
		arcade_pkg::key_code_e code;
		code = code.first();
		repeat (code.num()) begin
			send_key(code, 1'b1, 1'b1);
			check_value($sformatf("controls on press %02h", code), int'(ctl_vec),
				int'(key_ctl(code)));
			send_key(code, 1'b0, 1'b1);
			check_value($sformatf("controls on release %02h", code), int'(ctl_vec), 0);
			code = code.next();
		end
		send_key(8'h1C, 1'b1, 1'b1);
		check_value("controls on unknown key", int'(ctl_vec), 0);
		send_key(8'h1C, 1'b0, 1'b1);
		send_key(arcade_pkg::KEY_COIN, 1'b1, 1'b0);
		check_value("controls on press without toggle", int'(ctl_vec), 0);
	endtask

	task automatic run_rotation();
		for (int rot = 0; rot < 2; rot++) begin
			rotate = 1'(rot);
			for (int d = 0; d < 4; d++) begin
				send_key(dir_codes[d], 1'b1, 1'b1);
				send_key(dir_codes[d], 1'b0, 1'b1);
				joy_0 = `ARC_JOY_W'(1 << d);
				repeat (2) @(negedge clk_24);
				joy_0 = '0;
				joy_1 = `ARC_JOY_W'(1 << d);
				repeat (2) @(negedge clk_24);
				joy_1 = '0;
			end
		end
		rotate = 1'b1;
	endtask

	task automatic run_merge();
		send_key(arcade_pkg::KEY_FIRE1, 1'b1, 1'b1);
		send_key(arcade_pkg::KEY_LEFT, 1'b1, 1'b1);
		repeat (300) begin
			@(negedge clk_24);
			joy_0  = `ARC_JOY_W'($urandom);
			joy_1  = `ARC_JOY_W'($urandom);
			rotate = 1'($urandom);
		end
		{joy_0, joy_1, rotate} = {16'd0, 1'b1};
		send_key(arcade_pkg::KEY_FIRE1, 1'b0, 1'b1);
		send_key(arcade_pkg::KEY_LEFT, 1'b0, 1'b1);
	endtask

	task automatic check_audio();
		logic [`ARC_SND_W-1:0] a, b;
		int ones;
		a = `ARC_SND_W'($urandom);
		b = `ARC_SND_W'($urandom);
		ones = 0;
		@(negedge clk_24);
		{sample_strobe, snd_a, snd_b} = {1'b1, a, b};
		@(negedge clk_24);
		sample_strobe = 1'b0;
		repeat (65536) begin  // Window opens one cycle after the strobe
			@(negedge clk_24);
			ones += int'(audio_l);
		end
		check_value("audio ones count", ones, (4 * int'(b) + int'(a)) * 32);
	endtask

	task automatic run_video();
		for (int lvl = 0; lvl < 4; lvl++) begin
			scanlines = 2'(lvl);
			send_pixel(3'd0, 3'd0, 3'd0, 1'b0, 1'b1, 1'b0, 1'b1);  // Frame start
			send_pixel(3'd0, 3'd0, 3'd0, 1'b0, 1'b1, 1'b0, 1'b0);
			repeat (6) begin
				send_pixel(3'd0, 3'd0, 3'd0, 1'b1, 1'b0, 1'b1, 1'b0);
				repeat (8) begin
					send_pixel(3'($urandom), 3'($urandom), 3'($urandom),
						1'(($urandom % 6) == 0), 1'b0, 1'b0, 1'b0);
				end
				send_pixel(3'd0, 3'd0, 3'd0, 1'b1, 1'b0, 1'b0, 1'b0);  // Blanked porch
			end
		end
		repeat (2) send_pixel(3'd0, 3'd0, 3'd0, 1'b1, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		void'($urandom(60967));
		arst_n    = 1'b0;
		key_event = '0;
		rotate    = 1'b1;
		scanlines = 2'd0;
		{joy_0, joy_1} = '0;
		{sample_strobe, snd_a, snd_b} = '0;
		{ce_pix, hblank, vblank, hsync_in, vsync_in} = '0;
		{red_in, green_in, blue_in} = '0;
		repeat (5) @(posedge clk_24);
		@(negedge clk_24);
		arst_n = 1'b1;
		run_keyboard();
		run_rotation();
		run_merge();
		repeat (2) check_audio();
		run_video();
		finish_run(1'b0);
	end

endmodule

//--- all.f
+incdir+.
arcade_pkg.sv
key_decoder.sv
control_mapper.sv
audio_dac.sv
video_shade.sv
arcade_io_top.sv
arcade_io_assert.sv
tb_arcade_io.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_arcade_io
FILELIST  = all.f
HEADERS   = arcade_cfg.svh
SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
